// File: hw/decode_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module decode_stage (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  mips_pkg::fetch_pkt_t  i_fetch,
    input  mips_pkg::reg_write_t  i_reg_write,
    input  mips_pkg::reg_addr_t   i_rb_address,
    output mips_pkg::issue_pkt_t  o_issue,
    output logic                  o_fetch_hold,
    output mips_pkg::word_t       o_rb_data
);

    localparam int RF_DEPTH = 1 << `MIPS_NB_REG;

    mips_pkg::word_t      regs [RF_DEPTH];
    mips_pkg::issue_pkt_t issue_d;
    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic [15:0]          imm16;
    mips_pkg::reg_addr_t  rs;
    mips_pkg::reg_addr_t  rt;
    mips_pkg::reg_addr_t  rd;
    logic                 is_halt;
    logic                 hold_q;

    assign opcode = i_fetch.instr[31:26];
    assign rs     = i_fetch.instr[25:21];
    assign rt     = i_fetch.instr[20:16];
    assign rd     = i_fetch.instr[15:11];
    assign funct  = i_fetch.instr[5:0];
    assign imm16  = i_fetch.instr[15:0];

    // Write-through read, r0 hardwired to zero
    function automatic mips_pkg::word_t rf_read(input mips_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_reg_write.en && (i_reg_write.addr == addr)) begin
            return i_reg_write.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        issue_d         = '0;
        issue_d.alu_op  = mips_pkg::ALU_PASS_B;
        issue_d.data_a  = rf_read(rs);
        issue_d.data_b  = rf_read(rt);
        issue_d.shamt   = i_fetch.instr[10:6];
        issue_d.rs      = rs;
        issue_d.rt      = rt;
        issue_d.dest    = rt;
        issue_d.pc      = i_fetch.pc;
        case (opcode)
            `OP_RTYPE: begin
                issue_d.dest      = rd;
                issue_d.reg_write = 1'b1;
                case (funct)
                    `FN_ADDU: issue_d.alu_op = mips_pkg::ALU_ADD;
                    `FN_SUBU: issue_d.alu_op = mips_pkg::ALU_SUB;
                    `FN_AND:  issue_d.alu_op = mips_pkg::ALU_AND;
                    `FN_OR:   issue_d.alu_op = mips_pkg::ALU_OR;
                    `FN_XOR:  issue_d.alu_op = mips_pkg::ALU_XOR;
                    `FN_SLT:  issue_d.alu_op = mips_pkg::ALU_SLT;
                    `FN_SLL:  issue_d.alu_op = mips_pkg::ALU_SLL;
                    default:  issue_d.reg_write = 1'b0;  // Unknown funct is a nop
                endcase
            end
            `OP_ADDIU: begin
                issue_d.alu_op    = mips_pkg::ALU_ADD;
                issue_d.use_imm   = 1'b1;
                issue_d.imm       = {{16{imm16[15]}}, imm16};
                issue_d.reg_write = 1'b1;
            end
            `OP_ORI: begin
                issue_d.alu_op    = mips_pkg::ALU_OR;
                issue_d.use_imm   = 1'b1;
                issue_d.imm       = {16'b0, imm16};
                issue_d.reg_write = 1'b1;
            end
            `OP_LUI: begin
                issue_d.alu_op    = mips_pkg::ALU_LUI;
                issue_d.use_imm   = 1'b1;
                issue_d.imm       = {16'b0, imm16};
                issue_d.reg_write = 1'b1;
            end
            `OP_HALT: issue_d.halt = 1'b1;
            default: ;
        endcase
    end

    assign is_halt      = (opcode == `OP_HALT);
    assign o_fetch_hold = hold_q || is_halt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (i_reg_write.en && (i_reg_write.addr != '0)) begin
            regs[i_reg_write.addr] <= i_reg_write.data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            hold_q <= 1'b0;
        end else if (is_halt) begin
            hold_q <= 1'b1;
        end
    end

    // ID/EX register
    always_ff @(posedge i_clock) begin
        o_issue <= issue_d;
        if (i_rst) begin
            o_issue.reg_write <= 1'b0;
            o_issue.halt      <= 1'b0;
        end
    end

    always_comb begin
        o_rb_data = rf_read(i_rb_address);  // Debug read
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  mips_pkg::issue_pkt_t  i_issue,
    input  mips_pkg::exec_pkt_t   i_fwd,
    output mips_pkg::exec_pkt_t   o_exec
);

    logic            fwd_a;
    logic            fwd_b;
    mips_pkg::word_t op_a;
    mips_pkg::word_t reg_b;
    mips_pkg::word_t op_b;
    mips_pkg::word_t result;

    // Result one stage ahead overrides stale register values
    assign fwd_a = i_fwd.reg_write && (i_fwd.dest != '0) && (i_fwd.dest == i_issue.rs);
    assign fwd_b = i_fwd.reg_write && (i_fwd.dest != '0) && (i_fwd.dest == i_issue.rt);

    assign op_a  = fwd_a ? i_fwd.result : i_issue.data_a;
    assign reg_b = fwd_b ? i_fwd.result : i_issue.data_b;
    assign op_b  = i_issue.use_imm ? i_issue.imm : reg_b;

    always_comb begin
        case (i_issue.alu_op)
            mips_pkg::ALU_ADD: begin
                result = op_a + op_b;
            end
            mips_pkg::ALU_SUB: begin
                result = op_a - op_b;
            end
            mips_pkg::ALU_AND: begin
                result = op_a & op_b;
            end
            mips_pkg::ALU_OR: begin
                result = op_a | op_b;
            end
            mips_pkg::ALU_XOR: begin
                result = op_a ^ op_b;
            end
            mips_pkg::ALU_SLT: begin
                result = {31'b0, ($signed(op_a) < $signed(op_b))};  // Signed compare
            end
            mips_pkg::ALU_SLL: begin
                result = op_b << i_issue.shamt;
            end
            mips_pkg::ALU_LUI: begin
                result = {op_b[15:0], 16'b0};
            end
            default: begin
                result = op_b;  // PASS_B
            end
        endcase
    end

    always_comb begin
        o_exec.result    = result;
        o_exec.dest      = i_issue.dest;
        o_exec.reg_write = i_issue.reg_write;
        o_exec.halt      = i_issue.halt;
        o_exec.pc        = i_issue.pc;
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module fetch_stage (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  logic                  i_run,
    input  logic                  i_fetch_hold,
    input  logic                  i_im_write_enable,
    input  mips_pkg::im_addr_t    i_im_address,
    input  mips_pkg::byte_t       i_im_data,
    output mips_pkg::fetch_pkt_t  o_fetch,
    output mips_pkg::pc_t         o_last_pc
);

    localparam int IM_DEPTH = 1 << `MIPS_NB_IM_ADDR;

    mips_pkg::byte_t  imem [IM_DEPTH];
    mips_pkg::pc_t    pc;
    mips_pkg::word_t  instr;
    logic [`MIPS_NB_IM_ADDR-3:0] word_idx;
    logic             advance;

    assign advance  = i_run && !i_fetch_hold;
    assign word_idx = pc[`MIPS_NB_IM_ADDR-1:2];

    // Big endian, lowest byte address is the MSB
    assign instr = {imem[{word_idx, 2'd0}],
                    imem[{word_idx, 2'd1}],
                    imem[{word_idx, 2'd2}],
                    imem[{word_idx, 2'd3}]};

    always_ff @(posedge i_clock) begin
        if (i_im_write_enable) begin
            imem[i_im_address] <= i_im_data;  // Debug loader
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register, a zero word is the bubble
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_fetch <= '0;
        end else if (advance) begin
            o_fetch.instr <= instr;
            o_fetch.pc    <= pc;
        end else begin
            o_fetch.instr <= '0;  // Keep pc for o_last_pc
        end
    end

    assign o_last_pc = o_fetch.pc;

endmodule

// File: hw/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Data path widths
`define MIPS_NB_DATA    32
`define MIPS_NB_REG     5
`define MIPS_NB_PC      32
`define MIPS_NB_IM_ADDR 8
`define MIPS_NB_BYTE    8

// Opcodes
`define OP_RTYPE 6'b000000
`define OP_ADDIU 6'b001001
`define OP_ORI   6'b001101
`define OP_LUI   6'b001111
`define OP_HALT  6'b111111

// R-type funct codes
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_SLT   6'b101010
`define FN_SLL   6'b000000

`endif

// File: hw/mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  logic                 i_run,
    input  logic                 i_im_write_enable,
    input  mips_pkg::im_addr_t   i_im_address,
    input  mips_pkg::byte_t      i_im_data,
    input  mips_pkg::reg_addr_t  i_rb_address,
    output mips_pkg::word_t      o_rb_data,
    output logic                 o_hlt,
    output mips_pkg::pc_t        o_last_pc
);

    mips_pkg::fetch_pkt_t  if_id;
    mips_pkg::issue_pkt_t  id_ex;
    mips_pkg::exec_pkt_t   ex_result;
    mips_pkg::exec_pkt_t   ex_wb;
    mips_pkg::reg_write_t  wb_reg_write;
    logic                  fetch_hold;

    fetch_stage fetch_stage_1 (
        .i_clock           (i_clock),
        .i_rst             (i_rst),
        .i_run             (i_run),
        .i_fetch_hold      (fetch_hold),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .o_fetch           (if_id),
        .o_last_pc         (o_last_pc)
    );

    decode_stage decode_stage_1 (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_fetch      (if_id),
        .i_reg_write  (wb_reg_write),
        .i_rb_address (i_rb_address),  // Debug read
        .o_issue      (id_ex),
        .o_fetch_hold (fetch_hold),
        .o_rb_data    (o_rb_data)
    );

    execute_stage execute_stage_1 (
        .i_issue (id_ex),
        .i_fwd   (ex_wb),
        .o_exec  (ex_result)
    );

    writeback_stage writeback_stage_1 (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_exec      (ex_result),
        .o_fwd       (ex_wb),
        .o_reg_write (wb_reg_write),
        .o_hlt       (o_hlt)
    );

endmodule

// File: hw/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`MIPS_NB_DATA-1:0]    word_t;
    typedef logic [`MIPS_NB_REG-1:0]     reg_addr_t;
    typedef logic [`MIPS_NB_PC-1:0]      pc_t;
    typedef logic [`MIPS_NB_IM_ADDR-1:0] im_addr_t;
    typedef logic [`MIPS_NB_BYTE-1:0]    byte_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        word_t instr;
        pc_t   pc;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;    // B operand from imm
        word_t     data_a;
        word_t     data_b;
        word_t     imm;        // Already extended
        logic [4:0] shamt;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        logic      reg_write;
        logic      halt;
        pc_t       pc;
    } issue_pkt_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t dest;
        logic      reg_write;
        logic      halt;
        pc_t       pc;
    } exec_pkt_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

endpackage

// File: hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  mips_pkg::exec_pkt_t   i_exec,
    output mips_pkg::exec_pkt_t   o_fwd,
    output mips_pkg::reg_write_t  o_reg_write,
    output logic                  o_hlt
);

    // EX/WB register
    always_ff @(posedge i_clock) begin
        o_fwd <= i_exec;
        if (i_rst) begin
            o_fwd.reg_write <= 1'b0;
            o_fwd.halt      <= 1'b0;
        end
    end

    // r0 writes dropped here
    assign o_reg_write.en   = o_fwd.reg_write && (o_fwd.dest != '0);
    assign o_reg_write.addr = o_fwd.dest;
    assign o_reg_write.data = o_fwd.result;

    // Sticky until reset
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_hlt <= 1'b0;
        end else if (o_fwd.halt) begin
            o_hlt <= 1'b1;
        end
    end

endmodule

// File: mips_pipeline.f
+incdir+hw
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/mips_pipeline.sv
verif/tb_clock_gen.sv
verif/tb_mips_pipeline.sv

// File: verif/mips_trace.txt
# T name | L byte_addr b0 b1 b2 b3 (b0 is the MSB) | R reg(decimal) expected
# P expected o_last_pc | E end of test; all other numbers are hex
T alu
L 00 34 01 80 F0  ori   r1, r0, 0x80f0
L 04 24 02 FF F0  addiu r2, r0, -16
L 08 3C 03 80 01  lui   r3, 0x8001
L 0C 00 22 28 21  addu  r5, r1, r2
L 10 00 22 30 23  subu  r6, r1, r2
L 14 00 22 38 24  and   r7, r1, r2
L 18 00 61 40 25  or    r8, r3, r1
L 1C 00 22 48 26  xor   r9, r1, r2
L 20 00 41 50 2A  slt   r10, r2, r1
L 24 00 01 59 00  sll   r11, r1, 4
L 28 FC 00 00 00  halt
R 1 000080F0
R 2 FFFFFFF0
R 3 80010000
R 5 000080E0
R 6 00008100
R 7 000080F0
R 8 800180F0
R 9 FFFF7F00
R 10 00000001
R 11 00080F00
P 00000028
E
T depend
L 00 34 01 00 05  ori   r1, r0, 5
L 04 00 21 10 21  addu  r2, r1, r1
L 08 00 41 18 21  addu  r3, r2, r1
L 0C 24 60 00 07  addiu r0, r3, 7
L 10 00 03 20 21  addu  r4, r0, r3
L 14 FC 00 00 00  halt
L 18 34 05 12 34  ori   r5, r0, 0x1234
R 0 00000000
R 1 00000005
R 2 0000000A
R 3 0000000F
R 4 0000000F
R 5 00000000
P 00000014
E

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    input  logic i_restart,
    output logic o_clock,
    output logic o_rst
);

    int cycles = 0;

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_clock = ~o_clock;
    end

    // Reset stays high until the count runs out
    always @(posedge o_clock) begin
        if (i_restart) begin
            cycles <= 0;
        end else if (cycles < RESET_CYCLES) begin
            cycles <= cycles + 1;
        end
    end

    assign o_rst = (cycles < RESET_CYCLES);

endmodule

// File: verif/tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline;

    logic                 clock;
    logic                 rst;
    logic                 restart;
    logic                 run;
    logic                 im_write_enable;
    mips_pkg::im_addr_t   im_address;
    mips_pkg::byte_t      im_data;
    mips_pkg::reg_addr_t  rb_address;
    mips_pkg::word_t      rb_data;
    logic                 hlt;
    mips_pkg::pc_t        last_pc;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    n_instr;
    bit    program_ran;
    bit    timed_out = 1'b0;
    string test_name;

    tb_clock_gen clock_gen (
        .i_restart (restart),
        .o_clock   (clock),
        .o_rst     (rst)
    );

    mips_pipeline uut (
        .i_clock           (clock),
        .i_rst             (rst),
        .i_run             (run),
        .i_im_write_enable (im_write_enable),
        .i_im_address      (im_address),
        .i_im_data         (im_data),
        .i_rb_address      (rb_address),
        .o_rb_data         (rb_data),
        .o_hlt             (hlt),
        .o_last_pc         (last_pc)
    );

    task automatic step();
        @(posedge clock);
        #1;  // Drive just after the edge
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input mips_pkg::pc_t got,
                            input mips_pkg::pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reset_core();
        run     = 1'b0;
        restart = 1'b1;
        step();
        restart = 1'b0;
        while (rst) begin
            step();
        end
    endtask

    task automatic load_bytes(input int addr, input int b0, input int b1,
                              input int b2, input int b3);
        int bytes [4];
        bytes = '{b0, b1, b2, b3};
        for (int i = 0; i < 4; i++) begin
            im_write_enable = 1'b1;
            im_address      = mips_pkg::im_addr_t'(addr + i);
            im_data         = mips_pkg::byte_t'(bytes[i]);
            step();
        end
        im_write_enable = 1'b0;
    endtask

    task automatic run_to_halt();
        int limit;
        int count;
        limit = 4 * n_instr + 20;
        count = 0;
        run   = 1'b1;
        while (!hlt && !timed_out) begin
            step();
            count++;
            if (!hlt && count > limit) begin
                $display("Test %s: halt never arrived within %0d cycles", test_name, limit);
                timed_out = 1'b1;
                errors++;
            end
        end
        program_ran = 1'b1;
    endtask

    task automatic read_register(input int r, input mips_pkg::word_t exp);
        rb_address = mips_pkg::reg_addr_t'(r);
        @(negedge clock);
        check_word($sformatf("o_rb_data[r%0d]", r), rb_data, exp);
        step();
    endtask

    initial begin
        int    fd;
        int    errors_at_start;
        int    addr, b0, b1, b2, b3;
        int    r;
        int    value;
        string line;
        byte   kind;

        restart         = 1'b0;
        run             = 1'b0;
        im_write_enable = 1'b0;
        im_address      = '0;
        im_data         = '0;
        rb_address      = '0;
        errors_at_start = 0;

        fd = $fopen("verif/mips_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verif/mips_trace.txt");
            errors++;
        end

        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            kind = (line.len() > 0) ? line.getc(0) : "#";
            if ((kind == "R" || kind == "P" || kind == "E") && !program_ran) begin
                run_to_halt();  // First check of a test starts the program
            end
            if (!timed_out) begin
                case (kind)
                    "T": begin
                        void'($sscanf(line, "T %s", test_name));
                        errors_at_start = errors;
                        n_instr         = 0;
                        program_ran     = 1'b0;
                        reset_core();
                    end
                    "L": begin
                        void'($sscanf(line, "L %h %h %h %h %h", addr, b0, b1, b2, b3));
                        load_bytes(addr, b0, b1, b2, b3);
                        n_instr++;
                    end
                    "R": begin
                        void'($sscanf(line, "R %d %h", r, value));
                        read_register(r, mips_pkg::word_t'(value));
                    end
                    "P": begin
                        void'($sscanf(line, "P %h", value));
                        check_pc("o_last_pc", last_pc, mips_pkg::pc_t'(value));
                    end
                    "E": begin
                        if (!hlt) begin
                            $display("Test %s: o_hlt dropped after the halt", test_name);
                            errors++;
                        end
                        run = 1'b0;
                        tests_run++;
                        if (errors == errors_at_start) begin
                            $display("Test %s: PASS", test_name);
                        end else begin
                            $display("Test %s: FAIL (%0d errors)", test_name,
                                     errors - errors_at_start);
                            tests_failed++;
                        end
                    end
                    default: ;  // Comment or blank line
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
